/* ex_pkg.sv */
// Shared widths, opcode groups, ALU codes and instruction formats imported by every execute file
package ex_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////
	localparam int word_w       = 64;
	localparam int prf_idx_w    = 6;	// Physical register tag
	localparam int rob_idx_w    = 5;
	localparam int func_w       = 5;
	localparam int mult_stages  = 8;
	localparam int mult_slice_w = word_w / mult_stages;	// Multiplier bits per stage
	localparam int shamt_w      = $clog2(word_w);

	// ALU function codes
	localparam logic [func_w-1:0] alu_addq   = 5'h00;
	localparam logic [func_w-1:0] alu_subq   = 5'h01;
	localparam logic [func_w-1:0] alu_and    = 5'h02;
	localparam logic [func_w-1:0] alu_bic    = 5'h03;
	localparam logic [func_w-1:0] alu_bis    = 5'h04;
	localparam logic [func_w-1:0] alu_ornot  = 5'h05;
	localparam logic [func_w-1:0] alu_xor    = 5'h06;
	localparam logic [func_w-1:0] alu_eqv    = 5'h07;
	localparam logic [func_w-1:0] alu_srl    = 5'h08;
	localparam logic [func_w-1:0] alu_sll    = 5'h09;
	localparam logic [func_w-1:0] alu_sra    = 5'h0a;
	localparam logic [func_w-1:0] alu_mulq   = 5'h0b;	// Goes to the multiplier only
	localparam logic [func_w-1:0] alu_cmpeq  = 5'h0c;
	localparam logic [func_w-1:0] alu_cmplt  = 5'h0d;
	localparam logic [func_w-1:0] alu_cmple  = 5'h0e;
	localparam logic [func_w-1:0] alu_cmpult = 5'h0f;
	localparam logic [func_w-1:0] alu_cmpule = 5'h10;

	localparam logic [word_w-1:0] alu_filler = 64'hbad0_c0de_bad0_c0de;	// Unused codes

	//////////////////////////////////////////////////////////////////////
	// Opcode groups from opcode[5:3]
	//////////////////////////////////////////////////////////////////////
	localparam logic [2:0] grp_mem_int = 3'b001;	// 0x08 LDA, LDAH
	localparam logic [2:0] grp_operate = 3'b010;	// 0x10 integer operate
	localparam logic [2:0] grp_jump    = 3'b011;	// 0x18 holds JSR
	localparam logic [2:0] grp_mem_ld  = 3'b100;	// 0x20 loads
	localparam logic [2:0] grp_mem_st  = 3'b101;	// 0x28 stores
	localparam logic [2:0] grp_br_lo   = 3'b110;	// 0x30 BR, BSR and FP branches
	localparam logic [2:0] grp_br_hi   = 3'b111;	// 0x38 integer conditional branches

	localparam logic [5:0] jsr_grp   = 6'h1a;
	localparam logic [5:0] br_inst   = 6'h30;
	localparam logic [5:0] bsr_inst  = 6'h34;
	localparam logic [5:0] fbeq_inst = 6'h31;
	localparam logic [5:0] fblt_inst = 6'h32;
	localparam logic [5:0] fble_inst = 6'h33;
	localparam logic [5:0] fbne_inst = 6'h35;
	localparam logic [5:0] fbge_inst = 6'h36;
	localparam logic [5:0] fbgt_inst = 6'h37;

	// Operand select codes
	localparam logic [1:0] opa_is_rega     = 2'h0;
	localparam logic [1:0] opa_is_mem_disp = 2'h1;
	localparam logic [1:0] opa_is_npc      = 2'h2;
	localparam logic [1:0] opa_is_not3     = 2'h3;
	localparam logic [1:0] opb_is_regb     = 2'h0;
	localparam logic [1:0] opb_is_alu_imm  = 2'h1;
	localparam logic [1:0] opb_is_br_disp  = 2'h2;

	//////////////////////////////////////////////////////////////////////
	// Instruction formats
	//////////////////////////////////////////////////////////////////////
	// In register form rb sits in the top five literal bits
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] ra;
		logic [7:0] lit;
		logic       lit_flag;
		logic [6:0] func;
		logic [4:0] rc;
	} op_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [15:0] disp;
	} mem_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  ra;
		logic [20:0] disp;
	} br_fmt_t;

	typedef union packed {
		op_fmt_t  op;
		mem_fmt_t mem;
		br_fmt_t  br;
	} instr_t;

endpackage

/* ex_if.sv */
// Issue and result bundles passed between the execute stage units
`timescale 1ns/1ns

interface ex_issue_if
	import ex_pkg::*;
();
	logic [word_w-1:0]    opa;	// Also the multiplicand
	logic [word_w-1:0]    opb;	// Also the multiplier
	logic [word_w-1:0]    cond_opa;	// Register a for the branch test
	logic [func_w-1:0]    func;
	logic [2:0]           cond_code;
	logic                 cond_branch;
	logic                 uncond_branch;
	logic [prf_idx_w-1:0] pdest;
	logic [rob_idx_w-1:0] rob_idx;
	logic                 alu_valid;
	logic                 mult_valid;

	modport src (
		output opa, opb, cond_opa, func, cond_code, cond_branch, uncond_branch,
		output pdest, rob_idx, alu_valid, mult_valid
	);

	modport alu (
		input opa, opb, cond_opa, func, cond_code, cond_branch, uncond_branch,
		input pdest, rob_idx, alu_valid
	);

	modport mult (input opa, opb, pdest, rob_idx, mult_valid);
endinterface

// One finished result with its tags
interface ex_result_if
	import ex_pkg::*;
();
	logic                 valid;
	logic [word_w-1:0]    value;
	logic [prf_idx_w-1:0] pdest;
	logic [rob_idx_w-1:0] rob_idx;

	modport src (output valid, value, pdest, rob_idx);
	modport dst (input valid, value, pdest, rob_idx);
endinterface

/* operand_select.sv */
// Decodes the issued instruction, picks ALU operands and steers the op to ALU or multiplier
`timescale 1ns/1ns

module operand_select
	import ex_pkg::*;
(
	input  logic                 ex_en,
	input  instr_t               instr,
	input  logic [word_w-1:0]    prega_value,
	input  logic [word_w-1:0]    pregb_value,
	input  logic [word_w-1:0]    npc,
	input  logic [func_w-1:0]    alu_func,
	input  logic [prf_idx_w-1:0] pdest_idx,
	input  logic [rob_idx_w-1:0] rob_idx,
	ex_issue_if.src              issue
);
	logic [word_w-1:0] mem_disp;
	logic [word_w-1:0] br_disp;
	logic [word_w-1:0] alu_imm;
	logic [1:0]        opa_sel;
	logic [1:0]        opb_sel;
	logic [2:0]        grp;

	assign grp = instr.op.opcode[5:3];

	// Immediates
	assign mem_disp = {{(word_w-16){instr.mem.disp[15]}}, instr.mem.disp};
	assign br_disp  = {{(word_w-23){instr.br.disp[20]}}, instr.br.disp, 2'b00};	// Word offset
	assign alu_imm  = {{(word_w-8){1'b0}}, instr.op.lit};

	//////////////////////////////////////////////////////////////////////
	// Operand select decode
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		opa_sel = opa_is_rega;
		opb_sel = opb_is_regb;
		case (grp)
			grp_operate:
				opb_sel = instr.op.lit_flag ? opb_is_alu_imm : opb_is_regb;
			grp_jump:
			begin
				if (instr.op.opcode == jsr_grp)
					opa_sel = opa_is_not3;	// Masks off the low two target bits
			end
			grp_mem_int, grp_mem_ld, grp_mem_st:
				opa_sel = opa_is_mem_disp;
			grp_br_lo, grp_br_hi:
			begin
				opa_sel = opa_is_npc;
				opb_sel = opb_is_br_disp;
			end
			default: ;
		endcase
	end

	always_comb
	begin
		case (opa_sel)
			opa_is_rega:     issue.opa = prega_value;
			opa_is_mem_disp: issue.opa = mem_disp;
			opa_is_npc:      issue.opa = npc;
			opa_is_not3:     issue.opa = {{(word_w-2){1'b1}}, 2'b00};
		endcase
		case (opb_sel)
			opb_is_alu_imm: issue.opb = alu_imm;
			opb_is_br_disp: issue.opb = br_disp;
			default:        issue.opb = pregb_value;
		endcase
	end

	// Branch kind
	always_comb
	begin
		issue.cond_branch   = 1'b0;
		issue.uncond_branch = 1'b0;
		case (grp)
			grp_jump:
				issue.uncond_branch = (instr.op.opcode == jsr_grp);
			grp_br_lo, grp_br_hi:
			begin
				case (instr.br.opcode)
					br_inst, bsr_inst:
						issue.uncond_branch = 1'b1;
					fbeq_inst, fblt_inst, fble_inst, fbne_inst, fbge_inst, fbgt_inst: ;	// No FP unit
					default:
						issue.cond_branch = 1'b1;
				endcase
			end
			default: ;
		endcase
	end

	assign issue.cond_opa  = prega_value;
	assign issue.cond_code = instr.br.opcode[2:0];
	assign issue.func      = alu_func;
	assign issue.pdest     = pdest_idx;
	assign issue.rob_idx   = rob_idx;

	// MULQ never goes through the ALU
	assign issue.mult_valid = ex_en & (alu_func == alu_mulq);
	assign issue.alu_valid  = ex_en & (alu_func != alu_mulq);

endmodule

/* alu_unit.sv */
// Combinational ALU with branch condition evaluation for the execute stage
`timescale 1ns/1ns

module alu_unit
	import ex_pkg::*;
(
	ex_issue_if.alu  issue,
	ex_result_if.src res,
	output logic     is_branch,
	output logic     taken
);
	logic [word_w-1:0]  result;
	logic [shamt_w-1:0] shamt;
	logic               cond;

	assign shamt = issue.opb[shamt_w-1:0];

	//////////////////////////////////////////////////////////////////////
	// Result
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		case (issue.func)
			alu_addq:   result = issue.opa + issue.opb;
			alu_subq:   result = issue.opa - issue.opb;
			alu_and:    result = issue.opa & issue.opb;
			alu_bic:    result = issue.opa & ~issue.opb;
			alu_bis:    result = issue.opa | issue.opb;
			alu_ornot:  result = issue.opa | ~issue.opb;
			alu_xor:    result = issue.opa ^ issue.opb;
			alu_eqv:    result = issue.opa ^ ~issue.opb;
			alu_srl:    result = issue.opa >> shamt;
			alu_sll:    result = issue.opa << shamt;
			alu_sra:    result = $signed(issue.opa) >>> shamt;
			alu_cmpeq:  result = word_w'(issue.opa == issue.opb);
			alu_cmpult: result = word_w'(issue.opa < issue.opb);
			alu_cmpule: result = word_w'(issue.opa <= issue.opb);
			alu_cmplt:  result = word_w'($signed(issue.opa) < $signed(issue.opb));
			alu_cmple:  result = word_w'($signed(issue.opa) <= $signed(issue.opb));
			default:    result = alu_filler;
		endcase
	end

	// Branch test on register a, not on opa which holds npc here
	always_comb
	begin
		case (issue.cond_code[1:0])
			2'b00:   cond = ~issue.cond_opa[0];	// Low bit clear
			2'b01:   cond = (issue.cond_opa == '0);
			2'b10:   cond = issue.cond_opa[word_w-1];	// Negative
			default: cond = issue.cond_opa[word_w-1] | (issue.cond_opa == '0);
		endcase
		if (issue.cond_code[2])
			cond = ~cond;
	end

	assign is_branch = issue.cond_branch | issue.uncond_branch;
	assign taken     = issue.uncond_branch | (issue.cond_branch & cond);

	assign res.valid   = issue.alu_valid;
	assign res.value   = result;
	assign res.pdest   = issue.pdest;
	assign res.rob_idx = issue.rob_idx;

endmodule

/* mult_pipe.sv */
// Eight stage pipelined 64 bit multiplier that carries each multiply's tags to the end
`timescale 1ns/1ns

module mult_pipe
	import ex_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	ex_issue_if.mult  issue,
	ex_result_if.src  res
);
	logic [word_w-1:0]    mcand [0:mult_stages-1];
	logic [word_w-1:0]    mplier [0:mult_stages-1];
	logic [word_w-1:0]    sum [1:mult_stages];	// Running partial sums
	logic [prf_idx_w-1:0] pdest [0:mult_stages];
	logic [rob_idx_w-1:0] rob [0:mult_stages];
	logic [mult_stages:0] valid;	// Bit k is stage k

	// Low slice of the multiplier times the shifted multiplicand
	function automatic logic [word_w-1:0] slice_prod(
		input logic [word_w-1:0] mp,
		input logic [word_w-1:0] mc
	);
		return word_w'(mp[mult_slice_w-1:0]) * mc;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////////////////////////
	// Stage 0 latches the operands and each later stage adds one slice
	always_ff @(posedge clk)
	begin
		mcand[0]  <= issue.opa;
		mplier[0] <= issue.opb;
		pdest[0]  <= issue.pdest;
		rob[0]    <= issue.rob_idx;
		sum[1]    <= slice_prod(mplier[0], mcand[0]);
		for (int k = 1; k < mult_stages; k++)
		begin
			mcand[k]  <= mcand[k-1] << mult_slice_w;
			mplier[k] <= mplier[k-1] >> mult_slice_w;
			sum[k+1]  <= sum[k] + slice_prod(mplier[k], mcand[k]);
		end
		for (int k = 1; k <= mult_stages; k++)
		begin
			pdest[k] <= pdest[k-1];	// Tags ride alongside
			rob[k]   <= rob[k-1];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			valid <= '0;
		else
			valid <= {valid[mult_stages-1:0], issue.mult_valid};	// Never stalls
	end

	assign res.valid   = valid[mult_stages];
	assign res.value   = sum[mult_stages];	// Low 64 product bits
	assign res.pdest   = pdest[mult_stages];
	assign res.rob_idx = rob[mult_stages];

endmodule

/* ex_writeback.sv */
// CDB arbitration and output register that gives the multiply result priority over the ALU
`timescale 1ns/1ns

module ex_writeback
	import ex_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	ex_result_if.dst             alu_res,
	ex_result_if.dst             mult_res,
	input  logic                 is_branch,
	input  logic                 taken,
	output logic                 cdb_valid,
	output logic [prf_idx_w-1:0] cdb_tag,
	output logic [word_w-1:0]    cdb_value,
	output logic [rob_idx_w-1:0] rob_idx_out,
	output logic                 is_branch_out,
	output logic                 branch_taken,
	output logic                 stall
);
	logic alu_wins;

	// Finishing multiply owns the CDB and upstream replays the ALU op
	assign stall    = mult_res.valid;
	assign alu_wins = alu_res.valid & ~mult_res.valid;

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cdb_valid     <= 1'b0;
			is_branch_out <= 1'b0;
			branch_taken  <= 1'b0;
		end
		else
		begin
			cdb_valid     <= mult_res.valid | alu_res.valid;
			is_branch_out <= alu_wins & is_branch;	// A multiply is never a branch
			branch_taken  <= alu_wins & taken;
		end
	end

	always_ff @(posedge clk)
	begin
		cdb_tag     <= mult_res.valid ? mult_res.pdest : alu_res.pdest;
		cdb_value   <= mult_res.valid ? mult_res.value : alu_res.value;
		rob_idx_out <= mult_res.valid ? mult_res.rob_idx : alu_res.rob_idx;
	end

endmodule

/* ex_stage.sv */
// Execute stage top level joining operand select, ALU, multiplier and CDB writeback
`timescale 1ns/1ns

module ex_stage
	import ex_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 ex_en,	// Issue valid
	input  instr_t               instr,
	input  logic [word_w-1:0]    prega_value,
	input  logic [word_w-1:0]    pregb_value,
	input  logic [word_w-1:0]    npc,
	input  logic [func_w-1:0]    alu_func,
	input  logic [prf_idx_w-1:0] pdest_idx,
	input  logic [rob_idx_w-1:0] rob_idx,
	output logic                 cdb_valid,
	output logic [prf_idx_w-1:0] cdb_tag,
	output logic [word_w-1:0]    cdb_value,
	output logic [rob_idx_w-1:0] rob_idx_out,
	output logic                 is_branch,
	output logic                 branch_taken,
	output logic                 stall
);
	logic alu_is_branch;
	logic alu_taken;

	ex_issue_if  issue ();
	ex_result_if alu_res ();
	ex_result_if mult_res ();

	operand_select u_opsel (
		.ex_en       (ex_en),
		.instr       (instr),
		.prega_value (prega_value),
		.pregb_value (pregb_value),
		.npc         (npc),
		.alu_func    (alu_func),
		.pdest_idx   (pdest_idx),
		.rob_idx     (rob_idx),
		.issue       (issue.src)
	);

	alu_unit u_alu (
		.issue     (issue.alu),
		.res       (alu_res.src),
		.is_branch (alu_is_branch),
		.taken     (alu_taken)
	);

	mult_pipe u_mult (
		.clk   (clk),
		.reset (reset),
		.issue (issue.mult),
		.res   (mult_res.src)
	);

	ex_writeback u_wb (
		.clk           (clk),
		.reset         (reset),
		.alu_res       (alu_res.dst),
		.mult_res      (mult_res.dst),
		.is_branch     (alu_is_branch),
		.taken         (alu_taken),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.cdb_value     (cdb_value),
		.rob_idx_out   (rob_idx_out),
		.is_branch_out (is_branch),
		.branch_taken  (branch_taken),
		.stall         (stall)
	);

endmodule

/* ex_stage_props.sv */
// Concurrent checks on reset, stall and CDB output behavior bound into the execute stage
`timescale 1ns/1ns

module ex_stage_props
	import ex_pkg::*;
(
	input logic              clk,
	input logic              reset,
	input logic              ex_en,
	input logic [func_w-1:0] alu_func,
	input logic              cdb_valid,
	input logic              is_branch,
	input logic              branch_taken,
	input logic              stall
);
	logic mul_issue;
	logic alu_issue;

	assign mul_issue = ex_en & (alu_func == alu_mulq);
	assign alu_issue = ex_en & (alu_func != alu_mulq);

	reset_clears: assert property (@(posedge clk)
		reset |=> !cdb_valid && !is_branch && !branch_taken && !stall)
		else $error("outputs not cleared after reset");

	// Each stall cycle belongs to a multiply issued nine cycles earlier
	stall_pairs: assert property (@(posedge clk) disable iff (reset)
		stall && $past(stall) |-> $past(mul_issue, 9) && $past(mul_issue, 10))
		else $error("stall high twice without back to back multiplies");

	cdb_follows: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> cdb_valid == ($past(stall) || $past(alu_issue)))
		else $error("cdb_valid does not follow issue or stall");

	mult_not_branch: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) && $past(stall) |-> !is_branch && !branch_taken)
		else $error("branch flags set on a multiply result");

endmodule

bind ex_stage ex_stage_props u_props (
	.clk          (clk),
	.reset        (reset),
	.ex_en        (ex_en),
	.alu_func     (alu_func),
	.cdb_valid    (cdb_valid),
	.is_branch    (is_branch),
	.branch_taken (branch_taken),
	.stall        (stall)
);

/* tb_ex_stage.sv */
// Directed testbench for the execute stage that runs as top module tb_ex_stage
`timescale 1ns/1ns

module tb_ex_stage
	import ex_pkg::*;
();
	localparam int period        = 100;
	localparam int reset_cycles  = 5;
	localparam int run_cycles    = reset_cycles + 48 + 8 + 49 + 17 + 13;	// Sum of test lengths
	localparam int margin_cycles = 50;

	logic                 clk;
	logic                 reset;
	logic                 ex_en;
	instr_t               instr;
	logic [word_w-1:0]    prega_value;
	logic [word_w-1:0]    pregb_value;
	logic [word_w-1:0]    npc;
	logic [func_w-1:0]    alu_func;
	logic [prf_idx_w-1:0] pdest_idx;
	logic [rob_idx_w-1:0] rob_idx;
	logic                 cdb_valid;
	logic [prf_idx_w-1:0] cdb_tag;
	logic [word_w-1:0]    cdb_value;
	logic [rob_idx_w-1:0] rob_idx_out;
	logic                 is_branch;
	logic                 branch_taken;
	logic                 stall;

	logic [31:0] lfsr;
	logic [7:0]  seq;	// Source of tags
	string       cur_test;
	int          tests;
	int          checks;
	int          fails;
	int          test_checks;
	int          test_fails;

	ex_stage dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers and reference model
	//////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [word_w-1:0] rand_bits(input int n);
		logic [word_w-1:0] w;
		w = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = lfsr_next(lfsr);
			w = {w[word_w-2:0], lfsr[0]};
		end
		return w;
	endfunction

	function automatic instr_t encode(input logic [5:0] opcode, input logic [25:0] fields);
		return {opcode, fields};
	endfunction

	function automatic logic [word_w-1:0] model_alu(input logic [func_w-1:0] f,
		input logic [word_w-1:0] a, input logic [word_w-1:0] b);
		logic [word_w-1:0] r;
		logic [word_w-1:0] msb;
		int                s;
		r = '0;
		msb = {1'b1, {(word_w-1){1'b0}}};
		s = int'(b[5:0]);
		case (f)
			alu_addq:   r = a + b;
			alu_subq:   r = a - b;
			alu_and:    r = a & b;
			alu_bic:    r = a & ~b;
			alu_bis:    r = a | b;
			alu_ornot:  r = a | ~b;
			alu_xor:    r = a ^ b;
			alu_eqv:    r = ~(a ^ b);
			alu_srl:    r = a >> s;
			alu_sll:    r = a << s;
			alu_sra:    r = (a >> s) | (a[word_w-1] ? ~({word_w{1'b1}} >> s) : '0);
			alu_cmpeq:  r[0] = (a == b);
			alu_cmpult: r[0] = (a < b);
			alu_cmpule: r[0] = (a <= b);
			alu_cmplt:  r[0] = ((a ^ msb) < (b ^ msb));	// Signed order by flipping the sign bit
			alu_cmple:  r[0] = ((a ^ msb) <= (b ^ msb));
			default:    r = 'x;
		endcase
		return r;
	endfunction

	// Integer conditional branches 0x38 to 0x3f in opcode order
	function automatic logic model_cond(input logic [2:0] code, input logic [word_w-1:0] a);
		case (code)
			3'd0:    return !a[0];	// BLBC
			3'd1:    return a == '0;	// BEQ
			3'd2:    return $signed(a) < 0;	// BLT
			3'd3:    return $signed(a) <= 0;
			3'd4:    return a[0];	// BLBS
			3'd5:    return a != '0;
			3'd6:    return $signed(a) >= 0;
			default: return $signed(a) > 0;	// BGT
		endcase
	endfunction

	task automatic step();
		@(posedge clk);
		#10;
	endtask

	task automatic drive(input logic en, input instr_t i, input logic [func_w-1:0] f,
		input logic [word_w-1:0] a, input logic [word_w-1:0] b, input logic [word_w-1:0] pc,
		input logic [prf_idx_w-1:0] tag, input logic [rob_idx_w-1:0] rob);
		ex_en = en;
		instr = i;
		alu_func = f;
		prega_value = a;
		pregb_value = b;
		npc = pc;
		pdest_idx = tag;
		rob_idx = rob;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////
	task automatic compare_word(input string what, input logic [word_w-1:0] exp,
		input logic [word_w-1:0] act);
		checks++;
		if (act !== exp)
		begin
			fails++;
			$display("error %s %s: expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic compare_tag(input string what, input logic [prf_idx_w-1:0] exp,
		input logic [prf_idx_w-1:0] act);
		checks++;
		if (act !== exp)
		begin
			fails++;
			$display("error %s %s: expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic compare_rob(input string what, input logic [rob_idx_w-1:0] exp,
		input logic [rob_idx_w-1:0] act);
		checks++;
		if (act !== exp)
		begin
			fails++;
			$display("error %s %s: expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic compare_bit(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp)
		begin
			fails++;
			$display("error %s %s: expected %b actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic check_cdb(input logic [word_w-1:0] value, input logic [prf_idx_w-1:0] tag,
		input logic [rob_idx_w-1:0] rob, input logic br, input logic tk);
		compare_bit("cdb_valid", 1'b1, cdb_valid);
		compare_word("cdb_value", value, cdb_value);
		compare_tag("cdb_tag", tag, cdb_tag);
		compare_rob("rob_idx_out", rob, rob_idx_out);
		compare_bit("is_branch", br, is_branch);
		compare_bit("branch_taken", tk, branch_taken);
	endtask

	// One ALU op with its result checked the cycle after issue
	task automatic run_alu(input instr_t i, input logic [func_w-1:0] f,
		input logic [word_w-1:0] a, input logic [word_w-1:0] b, input logic [word_w-1:0] pc,
		input logic [word_w-1:0] exp_value, input logic br, input logic tk);
		logic [prf_idx_w-1:0] tag;
		logic [rob_idx_w-1:0] rob;
		tag = seq[prf_idx_w-1:0];
		rob = seq[rob_idx_w-1:0];
		seq = seq + 8'd1;
		drive(1'b1, i, f, a, b, pc, tag, rob);
		step();
		ex_en = 1'b0;
		check_cdb(exp_value, tag, rob, br, tk);
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_checks = checks;
		test_fails = fails;
	endtask

	task automatic end_test();
		tests++;
		$display("%s: %0d checks, %0d errors", cur_test, checks - test_checks,
			fails - test_fails);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////
	task automatic test_operate();
		logic [word_w-1:0]   a;
		logic [word_w-1:0]   b;
		logic [7:0]          lit;
		logic [func_w-1:0]   f;
		begin_test("operate");
		for (int k = 0; k <= int'(alu_cmpule); k++)
		begin
			f = func_w'(k);
			if (f != alu_mulq)
			begin
				a = rand_bits(64);
				b = rand_bits(64);
				run_alu(encode(6'h10, {5'd1, 8'h40, 1'b0, 7'h20, 5'd3}), f, a, b, '0,
					model_alu(f, a, b), 1'b0, 1'b0);
				run_alu(encode(6'h10, {5'd1, 8'h40, 1'b0, 7'h20, 5'd3}), f, b, b, '0,
					model_alu(f, b, b), 1'b0, 1'b0);	// Equal operands for the compares
				a = rand_bits(64) | {1'b1, {(word_w-1){1'b0}}};	// Negative for sra and signed compares
				lit = 8'(rand_bits(8));
				run_alu(encode(6'h10, {5'd1, lit, 1'b1, 7'h20, 5'd3}), f, a, rand_bits(64), '0,
					model_alu(f, a, {{(word_w-8){1'b0}}, lit}), 1'b0, 1'b0);
			end
		end
		end_test();
	endtask

	task automatic test_memory();
		logic [15:0]       disp [0:3];
		logic [word_w-1:0] b;
		begin_test("memory");
		disp[0] = 16'h0010;
		disp[1] = 16'hfff0;
		disp[2] = 16'h7fff;
		disp[3] = 16'h8000;
		for (int k = 0; k < 8; k++)
		begin
			b = rand_bits(64);
			run_alu(encode(k < 4 ? 6'h08 : 6'h28, {5'd1, 5'd2, disp[k % 4]}), alu_addq,
				rand_bits(64), b, '0, b + {{48{disp[k % 4][15]}}, disp[k % 4]}, 1'b0, 1'b0);
		end
		end_test();
	endtask

	task automatic test_branch();
		logic [word_w-1:0] vals [0:4];
		logic [word_w-1:0] pc;
		logic [word_w-1:0] b;
		logic [20:0]       disp;
		logic [5:0]        op;
		begin_test("branch");
		vals[0] = '0;
		vals[1] = rand_bits(64) | {1'b1, {(word_w-1){1'b0}}};
		vals[2] = (rand_bits(63) & ~64'd1) | 64'd2;	// Positive and even
		vals[3] = rand_bits(63) | 64'd1;
		vals[4] = rand_bits(64) & ~64'd1;
		for (int c = 0; c < 8; c++)
		begin
			op = {3'b111, 3'(c)};
			for (int v = 0; v < 5; v++)
			begin
				pc = rand_bits(64) & ~64'd3;
				disp = 21'(rand_bits(21));
				run_alu(encode(op, {5'd4, disp}), alu_addq, vals[v], rand_bits(64), pc,
					pc + {{41{disp[20]}}, disp, 2'b00}, 1'b1, model_cond(3'(c), vals[v]));
			end
		end
		// BR, BSR, then the FP branches which never count as branches
		for (int k = 0; k < 8; k++)
		begin
			pc = rand_bits(64) & ~64'd3;
			disp = 21'(rand_bits(21));
			run_alu(encode({3'b110, 3'(k)}, {5'd4, disp}), alu_addq, rand_bits(64), '0, pc,
				pc + {{41{disp[20]}}, disp, 2'b00}, k == 0 || k == 4, k == 0 || k == 4);
		end
		b = rand_bits(64);
		run_alu(encode(6'h1a, {5'd26, 5'd2, 16'h4000}), alu_and, rand_bits(64), b, '0,
			b & ~64'd3, 1'b1, 1'b1);
		end_test();
	endtask

	task automatic test_multiply();
		logic [word_w-1:0]    a;
		logic [word_w-1:0]    b;
		logic [word_w-1:0]    exp_value [$];
		logic [prf_idx_w-1:0] exp_tag [$];
		logic [rob_idx_w-1:0] exp_rob [$];
		begin_test("multiply");
		for (int c = 0; c < 17; c++)
		begin
			if (c < 8)
			begin
				a = rand_bits(64);
				b = rand_bits(64);
				exp_value.push_back(a * b);
				exp_tag.push_back(seq[prf_idx_w-1:0]);
				exp_rob.push_back(seq[rob_idx_w-1:0]);
				drive(1'b1, encode(6'h13, {5'd1, 8'h40, 1'b0, 7'h20, 5'd3}), alu_mulq, a, b, '0,
					seq[prf_idx_w-1:0], seq[rob_idx_w-1:0]);
				seq = seq + 8'd1;
			end
			else
				ex_en = 1'b0;
			step();
			compare_bit("stall", c >= 8 && c < 16, stall);
			if (c >= 9)
				check_cdb(exp_value.pop_front(), exp_tag.pop_front(), exp_rob.pop_front(),
					1'b0, 1'b0);
			else
				compare_bit("cdb_valid", 1'b0, cdb_valid);
		end
		end_test();
	endtask

	task automatic test_collision();
		logic [word_w-1:0] a;
		logic [word_w-1:0] b;
		logic [word_w-1:0] x;
		logic [word_w-1:0] y;
		instr_t            i;
		int                waited;
		begin_test("collision");
		a = rand_bits(64);
		b = rand_bits(64);
		x = rand_bits(64);
		y = rand_bits(64);
		i = encode(6'h10, {5'd1, 8'h40, 1'b0, 7'h20, 5'd3});
		drive(1'b1, i, alu_mulq, a, b, '0, 6'h2a, 5'h15);
		step();
		ex_en = 1'b0;
		waited = 0;
		while (!stall && waited < 12)
		begin
			compare_bit("cdb_valid", 1'b0, cdb_valid);
			step();
			waited++;
		end
		if (!stall)
		begin
			fails++;
			$display("collision: stall did not rise within 12 cycles of the multiply");
		end
		else
		begin
			compare_bit("stall in multiply slot", 1'b1, waited == mult_stages);
			drive(1'b1, i, alu_addq, x, y, '0, 6'h11, 5'h0b);	// Lost to the multiply
			step();
			check_cdb(a * b, 6'h2a, 5'h15, 1'b0, 1'b0);
			compare_bit("stall", 1'b0, stall);
			step();	// Replayed op still on the inputs
			ex_en = 1'b0;
			check_cdb(x + y, 6'h11, 5'h0b, 1'b0, 1'b0);
			step();
			compare_bit("cdb_valid", 1'b0, cdb_valid);
		end
		end_test();
	endtask

	initial
	begin
		lfsr = 32'd93503;
		seq = 8'd0;
		tests = 0;
		checks = 0;
		fails = 0;
		reset = 1'b1;
		drive(1'b0, '0, alu_addq, '0, '0, '0, '0, '0);
		repeat (reset_cycles) @(posedge clk);
		#10;
		reset = 1'b0;
		test_operate();
		test_memory();
		test_branch();
		test_multiply();
		test_collision();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, fails);
		if (fails == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (run_cycles + margin_cycles) @(posedge clk);
		$display("timeout: tests still running after %0d cycles", run_cycles + margin_cycles);
		$display(">>> FAIL");
		$finish;
	end

endmodule

/* src.f */
ex_pkg.sv
ex_if.sv
operand_select.sv
alu_unit.sv
mult_pipe.sv
ex_writeback.sv
ex_stage.sv
ex_stage_props.sv
tb_ex_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '>>> FAIL' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
